// ==== include/osc_macros.svh ====
`ifndef OSC_MACROS_SVH
`define OSC_MACROS_SVH

// fixed point state words, s1.16
`define OSC_W 18
`define OSC_FRAC 16
`define ACC_W 21

// euler step, dt = 2^-9
`define DT_SHIFT 9
`define STEP_DIV 32

// raster geometry
`define SCREEN_W 640
`define PIX_X_W 10
`define PIX_Y_W 9
`define Y_BASE1 180
`define Y_BASE2 300

`define DAMP_G 2048 // 1/32 in s1.16
`define LINK_CREDITS 4

`endif

// ==== logic/euler_integrator.sv ====
`include "osc_macros.svh"

module euler_integrator #(
  parameter int DERIV_W = `ACC_W
) (
  input  logic                      AnalogClock,
  input  logic                      rst_n,
  input  logic                      load,
  input  logic                      step,
  input  osc_pkg::fix_t             init,
  input  logic signed [DERIV_W-1:0] deriv,
  output osc_pkg::fix_t             state
);
  import osc_pkg::*;

  logic signed [DERIV_W-1:0] deriv_dt; // deriv * dt
  fix_t                      incr;

  assign deriv_dt = deriv >>> `DT_SHIFT;
  assign incr     = fix_t'(deriv_dt); // truncates the acceleration guard bits

  always_ff @(posedge AnalogClock)
  begin
    if (!rst_n || load)
    begin
      state <= init;
    end
    else if (step)
    begin
      state <= state + incr;
    end
  end

endmodule

// ==== logic/osc_pkg.sv ====
`include "osc_macros.svh"

package osc_pkg;

  // position, velocity and spring coefficients
  typedef logic signed [`OSC_W-1:0] fix_t;

  // second derivative, three guard bits over fix_t
  typedef logic signed [`ACC_W-1:0] acc_t;

  // s1.16 multiply, full product then back to the state format
  function automatic fix_t fix_mul(input fix_t a, input fix_t b);
    logic signed [2*`OSC_W-1:0] prod;
    prod = a * b;
    fix_mul = fix_t'(prod >>> `OSC_FRAC); // drops the top guard bits
  endfunction

endpackage

// ==== logic/oscillator_core.sv ====
`include "osc_macros.svh"

module oscillator_core (
  input  logic          AnalogClock,
  input  logic          rst_n,
  input  logic          load_init,
  input  logic          cube,
  input  logic          step_ready,
  input  osc_pkg::fix_t k1,
  input  osc_pkg::fix_t k2,
  input  osc_pkg::fix_t kmid,
  input  osc_pkg::fix_t kcubic,
  input  osc_pkg::fix_t x1_init,
  input  osc_pkg::fix_t x2_init,
  input  osc_pkg::fix_t v1_init,
  input  osc_pkg::fix_t v2_init,
  output logic          step,
  output osc_pkg::fix_t x1,
  output osc_pkg::fix_t x2
);
  import osc_pkg::*;

  localparam int DIV_W = $clog2(`STEP_DIV);
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`STEP_DIV - 1);

  logic [DIV_W-1:0] div_cnt;
  fix_t             v1;
  fix_t             v2;
  acc_t             a1;
  acc_t             a2;

  // step period, parks on the last count while the plotter is busy
  always_ff @(posedge AnalogClock)
  begin
    if (!rst_n || load_init)
      div_cnt <= '0;
    else if (div_cnt != DIV_LAST)
      div_cnt <= div_cnt + 1'b1;
    else if (step_ready)
      div_cnt <= '0;
  end

  assign step = (div_cnt == DIV_LAST) && step_ready;

  spring_force force_i (
    .x1(x1), .x2(x2), .v1(v1), .v2(v2),
    .k1(k1), .k2(k2), .kmid(kmid), .kcubic(kcubic),
    .cube(cube), .a1(a1), .a2(a2)
  );

  // all four registers move on the same step from the old state
  euler_integrator #(.DERIV_W(`ACC_W)) v1_int_i (
    .AnalogClock(AnalogClock), .rst_n(rst_n), .load(load_init), .step(step),
    .init(v1_init), .deriv(a1), .state(v1)
  );

  euler_integrator #(.DERIV_W(`ACC_W)) v2_int_i (
    .AnalogClock(AnalogClock), .rst_n(rst_n), .load(load_init), .step(step),
    .init(v2_init), .deriv(a2), .state(v2)
  );

  euler_integrator #(.DERIV_W(`OSC_W)) x1_int_i (
    .AnalogClock(AnalogClock), .rst_n(rst_n), .load(load_init), .step(step),
    .init(x1_init), .deriv(v1), .state(x1)
  );

  euler_integrator #(.DERIV_W(`OSC_W)) x2_int_i (
    .AnalogClock(AnalogClock), .rst_n(rst_n), .load(load_init), .step(step),
    .init(x2_init), .deriv(v2), .state(x2)
  );

endmodule

// ==== logic/oscillator_top.sv ====
`include "osc_macros.svh"

module oscillator_top (
  input  logic                AnalogClock,
  input  logic                rst_n,
  input  logic                load_init,
  input  logic                trigger_draw,
  input  logic                cube,
  input  logic                pix_credit,
  input  osc_pkg::fix_t       k1,
  input  osc_pkg::fix_t       k2,
  input  osc_pkg::fix_t       kmid,
  input  osc_pkg::fix_t       kcubic,
  input  osc_pkg::fix_t       x1_init,
  input  osc_pkg::fix_t       x2_init,
  input  osc_pkg::fix_t       v1_init,
  input  osc_pkg::fix_t       v2_init,
  output osc_pkg::fix_t       x1,
  output osc_pkg::fix_t       x2,
  output logic                step,
  output logic                pix_valid,
  output logic [`PIX_X_W-1:0] pix_x,
  output logic [`PIX_Y_W-1:0] pix_y,
  output logic [1:0]          pix_color
);

  logic step_ready; // plotter idle, simulation may advance

  plot_if plot_bus ();

  oscillator_core core_i (
    .AnalogClock(AnalogClock), .rst_n(rst_n), .load_init(load_init),
    .cube(cube), .step_ready(step_ready),
    .k1(k1), .k2(k2), .kmid(kmid), .kcubic(kcubic),
    .x1_init(x1_init), .x2_init(x2_init), .v1_init(v1_init), .v2_init(v2_init),
    .step(step), .x1(x1), .x2(x2)
  );

  trace_plotter plotter_i (
    .AnalogClock(AnalogClock), .rst_n(rst_n), .trigger_draw(trigger_draw),
    .step(step), .x1(x1), .x2(x2),
    .step_ready(step_ready), .plot(plot_bus.source)
  );

  // back-pressure from the credits reaches the core through step_ready
  pixel_link link_i (
    .AnalogClock(AnalogClock), .rst_n(rst_n), .plot(plot_bus.sink),
    .pix_credit(pix_credit), .pix_valid(pix_valid),
    .pix_x(pix_x), .pix_y(pix_y), .pix_color(pix_color)
  );

endmodule

// ==== logic/pixel_link.sv ====
`include "osc_macros.svh"

// write queue toward the frame buffer, credit flow control
module pixel_link (
  input  logic                AnalogClock,
  input  logic                rst_n,
  plot_if.sink                plot,
  input  logic                pix_credit,
  output logic                pix_valid,
  output logic [`PIX_X_W-1:0] pix_x,
  output logic [`PIX_Y_W-1:0] pix_y,
  output logic [1:0]          pix_color
);

  localparam int DEPTH = 4;
  localparam int ENT_W = `PIX_X_W + `PIX_Y_W + 2;
  localparam int CRD_W = $clog2(`LINK_CREDITS + 1);

  logic [ENT_W-1:0] queue [DEPTH];
  logic [1:0]       wr_ptr;
  logic [1:0]       rd_ptr;
  logic [2:0]       fill;
  logic [CRD_W-1:0] credits;
  logic             push;
  logic             pop;

  assign plot.ready = (fill != 3'(DEPTH));
  assign push       = plot.valid && plot.ready;
  assign pix_valid  = (fill != '0) && (credits != '0);
  assign pop        = pix_valid; // one credit per beat

  always_ff @(posedge AnalogClock)
  begin
    if (!rst_n)
    begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      fill    <= '0;
      credits <= CRD_W'(`LINK_CREDITS);
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      fill <= fill + {2'b00, push} - {2'b00, pop};
      case ({pop, pix_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  always_ff @(posedge AnalogClock)
  begin
    if (push)
      queue[wr_ptr] <= {plot.x, plot.y, plot.color};
  end

  assign {pix_x, pix_y, pix_color} = queue[rd_ptr];

endmodule

// ==== logic/plot_if.sv ====
`include "osc_macros.svh"

// one pixel write, valid/ready handshake
interface plot_if;

  logic                  valid;
  logic [`PIX_X_W-1:0]   x;
  logic [`PIX_Y_W-1:0]   y;
  logic [1:0]            color; // 1 = trace 1, 2 = trace 2
  logic                  ready;

  modport source (
    output valid, x, y, color,
    input  ready
  );

  modport sink (
    input  valid, x, y, color,
    output ready
  );

endinterface

// ==== logic/spring_force.sv ====
`include "osc_macros.svh"

// accelerations of both masses, purely combinational
module spring_force (
  input  osc_pkg::fix_t x1,
  input  osc_pkg::fix_t x2,
  input  osc_pkg::fix_t v1,
  input  osc_pkg::fix_t v2,
  input  osc_pkg::fix_t k1,
  input  osc_pkg::fix_t k2,
  input  osc_pkg::fix_t kmid,
  input  osc_pkg::fix_t kcubic,
  input  logic          cube,
  output osc_pkg::acc_t a1,
  output osc_pkg::acc_t a2
);
  import osc_pkg::*;

  localparam fix_t ONE     = fix_t'(1 << `OSC_FRAC);
  localparam fix_t NEG_ONE = -ONE;
  localparam fix_t DAMP    = fix_t'(`DAMP_G);

  fix_t d;      // x2 - x1, stretch of the middle spring
  fix_t u;      // -1.0 - x1, mass 1 spring
  fix_t w;      // 1.0 - x2, mass 2 spring
  fix_t f_mid;
  fix_t f_k1;
  fix_t f_k2;
  fix_t f_g1;
  fix_t f_g2;
  fix_t u_sq;
  fix_t u_cu;
  fix_t f_cu;
  acc_t cu_term;

  assign d = x2 - x1;
  assign u = NEG_ONE - x1;
  assign w = ONE - x2;

  assign f_mid = fix_mul(kmid, d);
  assign f_k1  = fix_mul(k1, u);
  assign f_k2  = fix_mul(k2, w);
  assign f_g1  = fix_mul(DAMP, v1);
  assign f_g2  = fix_mul(DAMP, v2);

  // cubic stiffening of the mass 1 spring
  assign u_sq = fix_mul(u, u);
  assign u_cu = fix_mul(u_sq, u);
  assign f_cu = fix_mul(kcubic, u_cu);

  assign cu_term = cube ? acc_t'(f_cu) : '0;

  // sums in acc_t so the terms are sign extended first
  assign a1 = acc_t'(f_mid) + acc_t'(f_k1) + cu_term - acc_t'(f_g1);
  assign a2 = acc_t'(f_k2) - acc_t'(f_g2) - acc_t'(f_mid);

endmodule

// ==== logic/trace_plotter.sv ====
`include "osc_macros.svh"

module trace_plotter (
  input  logic          AnalogClock,
  input  logic          rst_n,
  input  logic          trigger_draw,
  input  logic          step,
  input  osc_pkg::fix_t x1,
  input  osc_pkg::fix_t x2,
  output logic          step_ready,
  plot_if.source        plot
);
  import osc_pkg::*;

  localparam int ROW_SHIFT = 11; // +-1.0 spans 64 rows

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_TRC1  = 2'd1;
  localparam logic [1:0] ST_TRC2  = 2'd2;

  localparam logic [`PIX_X_W-1:0] COL_END = `PIX_X_W'(`SCREEN_W);

  logic [1:0]          state;
  logic [`PIX_X_W-1:0] col;
  logic [`PIX_Y_W-1:0] row1;
  logic [`PIX_Y_W-1:0] row2;
  logic                xfer;

  // screen row of a position, up on screen is positive
  function automatic logic [`PIX_Y_W-1:0] row_of(input fix_t pos, input int base);
    fix_t scaled;
    scaled = pos >>> ROW_SHIFT;
    row_of = `PIX_Y_W'(base - scaled);
  endfunction

  assign xfer = plot.valid && plot.ready;

  always_ff @(posedge AnalogClock)
  begin
    if (!rst_n || trigger_draw)
    begin
      state <= ST_IDLE;
      col   <= '0;
    end
    else
    begin
      case (state)
        ST_IDLE:
        begin
          if (step && col < COL_END)
            state <= ST_TRC1;
        end
        ST_TRC1:
        begin
          if (xfer)
            state <= ST_TRC2;
        end
        ST_TRC2:
        begin
          if (xfer)
          begin
            state <= ST_IDLE;
            col   <= col + 1'b1; // next time column
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // rows sampled before the integrators move
  always_ff @(posedge AnalogClock)
  begin
    if (state == ST_IDLE && step)
    begin
      row1 <= row_of(x1, `Y_BASE1);
      row2 <= row_of(x2, `Y_BASE2);
    end
  end

  assign step_ready = (state == ST_IDLE);

  assign plot.valid = (state == ST_TRC1) || (state == ST_TRC2);
  assign plot.x     = col;
  assign plot.y     = (state == ST_TRC2) ? row2 : row1;
  assign plot.color = (state == ST_TRC2) ? 2'd2 : 2'd1;

endmodule

// ==== project.f ====
+incdir+include
logic/osc_pkg.sv
logic/plot_if.sv
logic/euler_integrator.sv
logic/spring_force.sv
logic/oscillator_core.sv
logic/trace_plotter.sv
logic/pixel_link.sv
logic/oscillator_top.sv
tb/tb_oscillator.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the oscillator testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_oscillator -f project.f -o sim_oscillator \
  && ./obj_dir/sim_oscillator | tee sim.log \
  || { echo "build or run failed"; exit 1; }

grep -q "TESTBENCH PASSED" sim.log && echo "simulation passed" && exit 0 \
  || { echo "simulation failed"; exit 1; }

// ==== tb/tb_oscillator.sv ====
`include "osc_macros.svh"

module tb_oscillator;
  import osc_pkg::*;

  localparam int ONE = 1 << `OSC_FRAC;
  localparam int STEP_LIMIT = 4 * `STEP_DIV;
  localparam fix_t DAMP = fix_t'(`DAMP_G);

  logic AnalogClock = 1'b0;
  logic rst_n;
  logic load_init;
  logic trigger_draw;
  logic cube;
  logic pix_credit = 1'b0;
  fix_t k1, k2, kmid, kcubic, x1_init, x2_init, v1_init, v2_init;
  fix_t x1, x2;
  logic step;
  logic pix_valid;
  logic [`PIX_X_W-1:0] pix_x;
  logic [`PIX_Y_W-1:0] pix_y;
  logic [1:0] pix_color;

  fix_t m_x1, m_x2, m_v1, m_v2; // reference state
  logic [`PIX_X_W+`PIX_Y_W+1:0] exp_q[$]; // {x, y, color} not yet seen on the link
  int ret_q[$]; // cycle at which each credit goes back
  logic [31:0] rng = 32'he8bb_eb95;
  int cyc, exp_col, outstanding, pairs_seen, errors, tests, failed;
  int since_step; // cycles since the last step pulse
  bit hold_credits, check_due, timed_out;

  always #50 AnalogClock = ~AnalogClock;

  oscillator_top dut_i (.*);

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // s1.16 product taken full width then scaled back
  function automatic fix_t q16(input fix_t a, input fix_t b);
    longint p;
    p = longint'(a) * longint'(b);
    return fix_t'(p >>> `OSC_FRAC);
  endfunction

  function automatic logic [`PIX_Y_W-1:0] screen_row(input fix_t pos, input int base);
    return `PIX_Y_W'(base - (int'(pos) >>> 11));
  endfunction

  task automatic report_mismatch(input string name, input longint exp, input longint got);
    errors++;
    $display("Fail at %0t: %s expected %0d, got %0d", $time, name, exp, got);
  endtask

  task automatic note_failure(input string msg);
    errors++;
    $display("%0t: %s", $time, msg);
  endtask

  // euler step where positions move with the old velocities
  task automatic advance_model();
    fix_t d, u, w, f_mid;
    int a1, a2;
    d = m_x2 - m_x1;
    u = fix_t'(-ONE - int'(m_x1));
    w = fix_t'(ONE - int'(m_x2));
    f_mid = q16(kmid, d);
    a1 = f_mid + q16(k1, u) - q16(DAMP, m_v1);
    if (cube)
      a1 = a1 + q16(kcubic, q16(q16(u, u), u));
    a2 = q16(k2, w) - q16(DAMP, m_v2) - f_mid;
    m_x1 = m_x1 + fix_t'(int'(m_v1) >>> `DT_SHIFT);
    m_x2 = m_x2 + fix_t'(int'(m_v2) >>> `DT_SHIFT);
    m_v1 = m_v1 + fix_t'(a1 >>> `DT_SHIFT);
    m_v2 = m_v2 + fix_t'(a2 >>> `DT_SHIFT);
  endtask

  always @(posedge AnalogClock)
  begin : monitor
    logic [`PIX_X_W-1:0] hx;
    logic [`PIX_Y_W-1:0] hy;
    logic [1:0] hc;
    if (!rst_n)
    begin
      exp_q.delete();
      ret_q.delete();
      outstanding <= 0;
      since_step <= 0;
      exp_col = 0;
      cyc = 0;
    end
    else
    begin
      cyc++;
      outstanding <= outstanding + int'(pix_valid) - int'(pix_credit);
      since_step <= step ? 0 : since_step + 1;
      if (pix_valid)
      begin
        ret_q.push_back(cyc + 1 + int'(next_rand() % 6));
        assert (exp_q.size() > 0) else note_failure("pixel write with none pending");
        if (exp_q.size() > 0)
        begin
          {hx, hy, hc} = exp_q.pop_front();
          assert (pix_x == hx) else report_mismatch("pix_x", hx, pix_x);
          assert (pix_y == hy) else report_mismatch("pix_y", hy, pix_y);
          assert (pix_color == hc) else report_mismatch("pix_color", hc, pix_color);
        end
        if (pix_color == 2'd2)
          pairs_seen++;
      end
      if (trigger_draw)
      begin
        exp_col = 0;
        pairs_seen = 0;
      end
      else if (step && exp_col < `SCREEN_W)
      begin
        exp_q.push_back({`PIX_X_W'(exp_col), screen_row(m_x1, `Y_BASE1), 2'd1});
        exp_q.push_back({`PIX_X_W'(exp_col), screen_row(m_x2, `Y_BASE2), 2'd2});
        exp_col++;
      end
    end
    if (!rst_n || load_init)
    begin
      m_x1 = x1_init;
      m_x2 = x2_init;
      m_v1 = v1_init;
      m_v2 = v2_init;
    end
    else if (step)
    begin
      advance_model();
      check_due = 1'b1;
    end
  end

  always @(negedge AnalogClock)
  begin
    if (check_due)
    begin
      check_due = 1'b0;
      assert (x1 == m_x1) else report_mismatch("x1", m_x1, x1);
      assert (x2 == m_x2) else report_mismatch("x2", m_x2, x2);
    end
  end

  // frame buffer returns one credit per cycle once its delay is over
  always @(negedge AnalogClock)
  begin
    if (!hold_credits && ret_q.size() > 0 && ret_q[0] <= cyc)
    begin
      void'(ret_q.pop_front());
      pix_credit <= 1'b1;
    end
    else
      pix_credit <= 1'b0;
  end

  assert property (@(posedge AnalogClock) disable iff (!rst_n)
    pix_valid |-> outstanding < `LINK_CREDITS)
    else note_failure("pixel write sent with no credit left");

  assert property (@(posedge AnalogClock) disable iff (!rst_n)
    step |-> since_step >= `STEP_DIV - 1)
    else note_failure("step came before a full divider period");

  task automatic wait_step();
    int n;
    n = 0;
    if (!timed_out)
    begin
      do
      begin
        @(negedge AnalogClock);
        n++;
      end
      while (!step && n < STEP_LIMIT);
      if (!step)
      begin
        timed_out = 1'b1;
        note_failure("no step pulse came");
      end
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    if (!timed_out)
    begin
      do
      begin
        @(negedge AnalogClock);
        n++;
      end
      while (exp_q.size() > 0 && n < STEP_LIMIT);
      if (exp_q.size() > 0)
      begin
        timed_out = 1'b1;
        note_failure("pixel writes never left the link");
      end
    end
  endtask

  task automatic load_state(input int x1i, x2i, v1i, v2i);
    @(negedge AnalogClock);
    x1_init <= fix_t'(x1i);
    x2_init <= fix_t'(x2i);
    v1_init <= fix_t'(v1i);
    v2_init <= fix_t'(v2i);
    load_init <= 1'b1;
    @(negedge AnalogClock);
    load_init <= 1'b0;
    assert (x1 == fix_t'(x1i)) else report_mismatch("x1", fix_t'(x1i), x1);
    assert (x2 == fix_t'(x2i)) else report_mismatch("x2", fix_t'(x2i), x2);
  endtask

  task automatic pulse_trigger();
    trigger_draw <= 1'b1;
    @(negedge AnalogClock);
    trigger_draw <= 1'b0;
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests++;
    if (errors != errs_before || timed_out)
      failed++;
    $display("test %-12s done, %0d errors", name, errors - errs_before);
  endtask

  initial
  begin
    int e0;
    int quiet;
    int n;
    rst_n = 1'b0;
    load_init = 1'b0;
    trigger_draw = 1'b0;
    cube = 1'b0;
    k1 = fix_t'(ONE);
    k2 = fix_t'(ONE);
    kmid = '0;
    kcubic = '0;
    x1_init = fix_t'(-ONE);
    x2_init = fix_t'(ONE);
    v1_init = '0;
    v2_init = '0;
    repeat (10) @(negedge AnalogClock);
    rst_n <= 1'b1;

    e0 = errors;
    for (int i = 0; i < `STEP_DIV - 1; i++)
    begin
      assert (!step && !pix_valid) else note_failure("activity before the first step period");
      @(negedge AnalogClock);
    end
    assert (step) else note_failure("no step at the end of the first period");
    load_state(-ONE + 3000, ONE - 2000, 0, 0);
    end_test("reset", e0);

    e0 = errors;
    for (int c = 0; c < 2; c++)
    begin
      cube <= c[0];
      kmid <= '0;
      kcubic <= fix_t'(ONE / 2);
      load_state(-ONE, ONE, 0, 0);
      repeat (50)
      begin
        wait_step();
        assert (x1 == fix_t'(-ONE)) else report_mismatch("x1", -ONE, x1);
        assert (x2 == fix_t'(ONE)) else report_mismatch("x2", ONE, x2);
      end
    end
    end_test("equilibrium", e0);

    e0 = errors;
    for (int c = 0; c < 2; c++)
    begin
      cube <= c[0];
      k1 <= fix_t'(ONE / 4 + int'(next_rand() % ONE));
      k2 <= fix_t'(ONE / 4 + int'(next_rand() % ONE));
      kmid <= fix_t'(next_rand() % (ONE / 2));
      kcubic <= fix_t'(next_rand() % ONE);
      load_state(-ONE - ONE / 4 + int'(next_rand() % (ONE / 2)),
                 ONE - ONE / 4 + int'(next_rand() % (ONE / 2)),
                 int'(next_rand() % 8192) - 4096, int'(next_rand() % 8192) - 4096);
      repeat (40) wait_step();
    end
    end_test("trajectory", e0);

    e0 = errors;
    wait_step();
    wait_drain();
    pulse_trigger();
    while (exp_col < `SCREEN_W && !timed_out)
      wait_step();
    repeat (5) wait_step(); // screen is full so these must not draw
    wait_drain();
    assert (pairs_seen == `SCREEN_W) else report_mismatch("pairs_seen", `SCREEN_W, pairs_seen);
    pulse_trigger();
    wait_step();
    wait_drain();
    assert (pairs_seen == 1) else report_mismatch("pairs_seen", 1, pairs_seen);
    end_test("plot stream", e0);

    e0 = errors;
    hold_credits <= 1'b1;
    quiet = 0;
    n = 0;
    while (quiet < 2 * `STEP_DIV && n < 12 * `STEP_DIV)
    begin
      @(negedge AnalogClock);
      n++;
      quiet = (step || pix_valid) ? 0 : quiet + 1;
    end
    assert (quiet >= 2 * `STEP_DIV)
      else note_failure("steps kept running with credits withheld");
    repeat (10 * `STEP_DIV)
    begin
      @(negedge AnalogClock);
      assert (!step && !pix_valid) else note_failure("activity while credits are withheld");
    end
    hold_credits <= 1'b0;
    repeat (30) wait_step();
    wait_drain();
    end_test("backpressure", e0);

    $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
    if (timed_out || errors != 0)
      $display("TESTBENCH FAILED");
    else
      $display("TESTBENCH PASSED");
    $finish;
  end

endmodule
